// File: all.f
src/capi_buffer_pkg.sv
src/line_ram.sv
src/dw_parity.sv
src/write_data_control.sv
src/buffer_config_regs.sv
src/capi_write_buffer_top.sv
sim/clock_gen.sv
sim/capi_write_buffer_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the write buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module capi_write_buffer_tb -f all.f -o capi_write_buffer_sim
./obj_dir/capi_write_buffer_sim | tee sim.log

if grep -q "all tests passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: sim/capi_write_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module capi_write_buffer_tb;

  localparam int half_bits      = capi_buffer_pkg::half_line_bits;
  localparam int dw_count       = capi_buffer_pkg::half_line_double_words;
  localparam int dw_bits        = capi_buffer_pkg::double_word_bits;
  localparam int tag_w          = capi_buffer_pkg::tag_bits;
  localparam int timeout_cycles = 3000;  // Far above the directed test length

  logic                                          clock;
  logic                                          rstn;
  logic                                          cfg_write;
  logic [capi_buffer_pkg::cfg_address_bits-1:0]  cfg_address;
  logic [capi_buffer_pkg::cfg_data_bits-1:0]     cfg_write_data;
  logic [capi_buffer_pkg::cfg_data_bits-1:0]     cfg_read_data;
  logic                                          command_write_valid;
  logic [tag_w-1:0]                              command_tag;
  logic [half_bits-1:0]                          write_data_0;
  logic [half_bits-1:0]                          write_data_1;
  logic                                          buffer_read_valid;
  logic [tag_w-1:0]                              buffer_read_tag;
  logic                                          buffer_read_tag_parity;
  logic [capi_buffer_pkg::read_address_bits-1:0] buffer_read_address;
  logic [half_bits-1:0]                          buffer_read_data;
  logic [dw_count-1:0]                           buffer_read_parity;
  logic                                          data_write_error;

  // Reference copy of both halves per tag
  logic [half_bits-1:0] model_half_0 [capi_buffer_pkg::buffer_depth];
  logic [half_bits-1:0] model_half_1 [capi_buffer_pkg::buffer_depth];
  logic [tag_w-1:0]     test_tags [6] = '{8'd0, 8'd1, 8'd37, 8'd128, 8'd200, 8'd255};

  integer seed        = 67485;
  int     error_count = 0;
  int     check_count = 0;
  int     cycle_count = 0;
  logic   odd_sense   = 1'b0;  // Sense last written to the control register

  clock_gen clock_gen_i (.clock(clock), .rstn(rstn));

  capi_write_buffer_top dut_i (
    .clock                  (clock),
    .rstn                   (rstn),
    .cfg_write              (cfg_write),
    .cfg_address            (cfg_address),
    .cfg_write_data         (cfg_write_data),
    .cfg_read_data          (cfg_read_data),
    .command_write_valid    (command_write_valid),
    .command_tag            (command_tag),
    .write_data_0           (write_data_0),
    .write_data_1           (write_data_1),
    .buffer_read_valid      (buffer_read_valid),
    .buffer_read_tag        (buffer_read_tag),
    .buffer_read_tag_parity (buffer_read_tag_parity),
    .buffer_read_address    (buffer_read_address),
    .buffer_read_data       (buffer_read_data),
    .buffer_read_parity     (buffer_read_parity),
    .data_write_error       (data_write_error)
  );

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // Parity bit picked so word plus bit has the asked ones count
  function automatic logic [dw_count-1:0] expected_parity(input logic [half_bits-1:0] data,
                                                          input logic odd);
    logic [dw_count-1:0] result;
    int                  ones;
    int                  d;
    int                  b;
    for (d = 0; d < dw_count; d++) begin
      ones = 0;
      for (b = 0; b < dw_bits; b++) begin
        if (data[d*dw_bits+b]) ones++;
      end
      result[d] = odd ? (ones % 2 == 0) : (ones % 2 == 1);
    end
    return result;
  endfunction

  function automatic logic tag_parity(input logic [tag_w-1:0] tag, input logic odd);
    int ones;
    int b;
    ones = 0;
    for (b = 0; b < tag_w; b++) begin
      if (tag[b]) ones++;
    end
    return odd ? (ones % 2 == 0) : (ones % 2 == 1);
  endfunction

  function automatic logic [half_bits-1:0] random_half();
    logic [half_bits-1:0] value;
    int                   w;
    for (w = 0; w < half_bits / 32; w++) begin
      value[w*32 +: 32] = $random(seed);
    end
    return value;
  endfunction

  // Zero picks half 0 and any nonzero value half 1
  function automatic logic [capi_buffer_pkg::read_address_bits-1:0] half_address(input logic half);
    logic [capi_buffer_pkg::read_address_bits-1:0] address;
    address = '0;
    if (half) begin
      address = 6'($random(seed));
      if (address == '0) address = 6'd1;
    end
    return address;
  endfunction

  ////////////////////////////////////////////////////////////
  // Drivers and checkers
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    error_count++;
    $display("[FAIL] at %0d ns: %s", $time, msg);
  endtask

  task automatic write_cfg(input logic [1:0] address, input logic [7:0] data);
    @(posedge clock);
    cfg_write      <= 1'b1;
    cfg_address    <= address;
    cfg_write_data <= data;
    @(posedge clock);
    cfg_write <= 1'b0;  // Register took the value at this edge
  endtask

  task automatic check_cfg(input logic [1:0] address, input logic [7:0] expected,
                           input string name);
    @(posedge clock);
    cfg_address <= address;
    @(negedge clock);  // Readback is combinational
    check_count++;
    if (cfg_read_data !== expected) begin
      report_failure($sformatf("%s reads 0x%02h, expected 0x%02h", name, cfg_read_data,
                               expected));
    end
  endtask

  task automatic set_control(input logic enable, input logic error_en, input logic odd);
    write_cfg(capi_buffer_pkg::cfg_control_address, {5'b0, odd, error_en, enable});
    odd_sense = odd;
  endtask

  task automatic write_line(input logic [tag_w-1:0] tag);
    logic [half_bits-1:0] half_0;
    logic [half_bits-1:0] half_1;
    half_0 = random_half();
    half_1 = random_half();
    @(posedge clock);
    command_write_valid <= 1'b1;
    command_tag         <= tag;
    write_data_0        <= half_0;
    write_data_1        <= half_1;
    @(posedge clock);
    command_write_valid <= 1'b0;
    model_half_0[tag] = half_0;
    model_half_1[tag] = half_1;
  endtask

  // Caller sits on a rising edge
  task automatic drive_request(input logic [tag_w-1:0] tag, input logic half,
                               input logic parity_ok);
    buffer_read_valid      <= 1'b1;
    buffer_read_tag        <= tag;
    buffer_read_address    <= half_address(half);
    buffer_read_tag_parity <= parity_ok ? tag_parity(tag, odd_sense) : ~tag_parity(tag, odd_sense);
  endtask

  // Compares the data shown in the current cycle
  task automatic check_response(input logic [tag_w-1:0] tag, input logic half, input logic idle,
                                input string what);
    logic [half_bits-1:0] exp_data;
    logic [dw_count-1:0]  exp_parity;
    if (idle) exp_data = '1;
    else if (half) exp_data = model_half_1[tag];
    else exp_data = model_half_0[tag];
    exp_parity = expected_parity(exp_data, odd_sense);
    check_count += 2;
    if (buffer_read_data !== exp_data) begin
      report_failure($sformatf("%s tag %0d half %0d: data mismatch", what, tag, half));
    end
    if (buffer_read_parity !== exp_parity) begin
      report_failure($sformatf("%s tag %0d half %0d: parity 0x%02h, expected 0x%02h", what, tag,
                               half, buffer_read_parity, exp_parity));
    end
  endtask

  task automatic single_read(input logic [tag_w-1:0] tag, input logic half);
    @(posedge clock);
    drive_request(tag, half, 1'b1);
    @(posedge clock);
    buffer_read_valid <= 1'b0;  // DUT samples the request here
    @(negedge clock);
    check_response(tag, half, 1'b0, "read");
  endtask

  // Watches five cycles for the error pulse due in the third
  task automatic send_tag_check(input logic [tag_w-1:0] tag, input logic parity_ok,
                                input logic expect_pulse);
    int pulses;
    int seen_at;
    int cycle;
    pulses  = 0;
    seen_at = -1;
    @(posedge clock);
    drive_request(tag, 1'b0, parity_ok);
    @(posedge clock);
    buffer_read_valid <= 1'b0;
    for (cycle = 0; cycle < 5; cycle++) begin
      @(negedge clock);
      if (data_write_error) begin
        pulses++;
        seen_at = cycle;
      end
    end
    check_count++;
    if (expect_pulse && (pulses != 1 || seen_at != 2)) begin
      report_failure($sformatf(
          "tag %0d: error pin high %0d times, last at %0d, expected once at 2",
          tag, pulses, seen_at));
    end
    if (!expect_pulse && pulses != 0) begin
      report_failure($sformatf("tag %0d: error pin high %0d times, expected none", tag, pulses));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge clock);
    check_count++;
    if (data_write_error !== 1'b0) report_failure("data_write_error high after reset");
    check_response('0, 1'b0, 1'b1, "after reset");
    check_cfg(capi_buffer_pkg::cfg_control_address, 8'h00, "control after reset");
  endtask

  task automatic test_odd_parity_reads();
    int i;
    set_control(1'b1, 1'b1, 1'b1);
    for (i = 0; i < 6; i++) write_line(test_tags[i]);
    for (i = 0; i < 6; i++) begin
      single_read(test_tags[i], 1'b0);
      single_read(test_tags[i], 1'b1);
    end
  endtask

  task automatic test_even_parity_reads();
    int i;
    set_control(1'b1, 1'b1, 1'b0);
    check_cfg(capi_buffer_pkg::cfg_control_address, 8'h03, "control even");
    for (i = 0; i < 6; i++) begin
      single_read(test_tags[i], 1'b0);
      single_read(test_tags[i], 1'b1);
    end
  endtask

  task automatic test_idle_all_ones();
    set_control(1'b1, 1'b0, 1'b1);
    @(negedge clock);
    check_response('0, 1'b0, 1'b1, "idle");
    single_read(test_tags[2], 1'b1);
    @(negedge clock);
    check_response('0, 1'b0, 1'b1, "between requests");
    set_control(1'b0, 1'b0, 1'b1);
    check_cfg(capi_buffer_pkg::cfg_control_address, 8'h04, "control disabled");
    @(posedge clock);
    drive_request(test_tags[3], 1'b0, 1'b1);
    @(posedge clock);
    buffer_read_valid <= 1'b0;
    @(negedge clock);
    check_response('0, 1'b0, 1'b1, "disabled read");
  endtask

  task automatic test_error_reporting();
    int i;
    set_control(1'b1, 1'b1, 1'b0);
    write_cfg(capi_buffer_pkg::cfg_status_address, 8'h00);
    write_cfg(capi_buffer_pkg::cfg_count_address, 8'h00);
    check_cfg(capi_buffer_pkg::cfg_count_address, 8'd0, "count before errors");
    for (i = 0; i < 3; i++) send_tag_check(test_tags[i], 1'b0, 1'b1);
    send_tag_check(test_tags[3], 1'b1, 1'b0);  // Good parity gives no pulse
    check_cfg(capi_buffer_pkg::cfg_status_address, 8'h01, "status after errors");
    check_cfg(capi_buffer_pkg::cfg_count_address, 8'd3, "count after errors");
    write_cfg(capi_buffer_pkg::cfg_status_address, 8'hff);
    check_cfg(capi_buffer_pkg::cfg_status_address, 8'h00, "status after clear");
    check_cfg(capi_buffer_pkg::cfg_count_address, 8'd3, "count after status clear");
    write_cfg(capi_buffer_pkg::cfg_count_address, 8'h5a);
    check_cfg(capi_buffer_pkg::cfg_count_address, 8'd0, "count after clear");
  endtask

  task automatic test_error_disabled();
    int i;
    set_control(1'b1, 1'b0, 1'b1);
    for (i = 0; i < 2; i++) send_tag_check(test_tags[i+4], 1'b0, 1'b0);
    check_cfg(capi_buffer_pkg::cfg_count_address, 8'd2, "count, reporting off");
    check_cfg(capi_buffer_pkg::cfg_status_address, 8'h01, "status, reporting off");
  endtask

  // New request every cycle with each response checked one cycle on
  task automatic test_back_to_back();
    int               i;
    logic [tag_w-1:0] tag;
    logic [tag_w-1:0] prev_tag;
    logic             half;
    logic             prev_half;
    set_control(1'b1, 1'b1, 1'b1);
    for (i = 0; i <= 16; i++) begin
      @(posedge clock);
      if (i < 16) begin
        tag  = test_tags[i % 6];
        half = i[0];
        drive_request(tag, half, 1'b1);
      end else begin
        buffer_read_valid <= 1'b0;
      end
      @(negedge clock);
      if (i > 0) check_response(prev_tag, prev_half, 1'b0, "back-to-back");
      check_count++;
      if (data_write_error !== 1'b0) report_failure("error pin high on good requests");
      prev_tag  = tag;
      prev_half = half;
    end
    @(negedge clock);
    check_response('0, 1'b0, 1'b1, "after burst");
  endtask

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  initial begin
    cfg_write              = 1'b0;
    cfg_address            = '0;
    cfg_write_data         = '0;
    command_write_valid    = 1'b0;
    command_tag            = '0;
    write_data_0           = '0;
    write_data_1           = '0;
    buffer_read_valid      = 1'b0;
    buffer_read_tag        = '0;
    buffer_read_tag_parity = 1'b0;
    buffer_read_address    = '0;
    wait (rstn === 1'b1);
    repeat (2) @(posedge clock);
    test_reset_state();
    test_odd_parity_reads();
    test_even_parity_reads();
    test_idle_all_ones();
    test_error_reporting();
    test_error_disabled();
    test_back_to_back();
    @(posedge clock);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Hang guard
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: tests still running after %0d clock cycles", timeout_cycles);
      $display("tests failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free running clock and power-on reset for the testbench
module clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic rstn
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;  // 50 ns half period
  end

  // Reset held for RESET_CYCLES rising edges and dropped at the last one
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

// File: src/capi_write_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module capi_write_buffer_top #(
  parameter int DEPTH          = capi_buffer_pkg::buffer_depth,
  parameter int HALF_LINE_BITS = capi_buffer_pkg::half_line_bits,
  parameter int DOUBLE_WORDS   = capi_buffer_pkg::half_line_double_words
) (
  input  logic                                          clock,
  input  logic                                          rstn,
  // Configuration port
  input  logic                                          cfg_write,
  input  logic [capi_buffer_pkg::cfg_address_bits-1:0]  cfg_address,
  input  logic [capi_buffer_pkg::cfg_data_bits-1:0]     cfg_write_data,
  output logic [capi_buffer_pkg::cfg_data_bits-1:0]     cfg_read_data,
  // Write side, from the accelerator
  input  logic                                          command_write_valid,
  input  logic [capi_buffer_pkg::tag_bits-1:0]          command_tag,
  input  logic [HALF_LINE_BITS-1:0]                     write_data_0,
  input  logic [HALF_LINE_BITS-1:0]                     write_data_1,
  // Read side, from the host link
  input  logic                                          buffer_read_valid,
  input  logic [capi_buffer_pkg::tag_bits-1:0]          buffer_read_tag,
  input  logic                                          buffer_read_tag_parity,
  input  logic [capi_buffer_pkg::read_address_bits-1:0] buffer_read_address,
  output logic [HALF_LINE_BITS-1:0]                     buffer_read_data,
  output logic [DOUBLE_WORDS-1:0]                       buffer_read_parity,
  output logic                                          data_write_error
);

  // Control levels and error feedback
  logic enabled;
  logic error_enable;
  logic odd_parity;
  logic tag_parity_error_pulse;

  ////////////////////////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////////////////////////

  buffer_config_regs config_regs_i (
    .clock                  (clock),
    .rstn                   (rstn),
    .cfg_write              (cfg_write),
    .cfg_address            (cfg_address),
    .cfg_write_data         (cfg_write_data),
    .cfg_read_data          (cfg_read_data),
    .tag_parity_error_pulse (tag_parity_error_pulse),
    .enabled                (enabled),
    .error_enable           (error_enable),
    .odd_parity             (odd_parity)
  );

  ////////////////////////////////////////////////////////////
  // Buffer datapath
  ////////////////////////////////////////////////////////////

  write_data_control #(
    .DEPTH          (DEPTH),
    .HALF_LINE_BITS (HALF_LINE_BITS)
  ) write_data_control_i (
    .clock                  (clock),
    .rstn                   (rstn),
    .enabled                (enabled),
    .error_enable           (error_enable),
    .odd_parity             (odd_parity),
    .command_write_valid    (command_write_valid),
    .command_tag            (command_tag),
    .write_data_0           (write_data_0),
    .write_data_1           (write_data_1),
    .buffer_read_valid      (buffer_read_valid),
    .buffer_read_tag        (buffer_read_tag),
    .buffer_read_tag_parity (buffer_read_tag_parity),
    .buffer_read_address    (buffer_read_address),
    .buffer_read_data       (buffer_read_data),
    .buffer_read_parity     (buffer_read_parity),   // DOUBLE_WORDS bits
    .data_write_error       (data_write_error),
    .tag_parity_error_pulse (tag_parity_error_pulse)
  );

endmodule

`default_nettype wire

// File: src/buffer_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_config_regs (
  input  logic                                         clock,
  input  logic                                         rstn,
  input  logic                                         cfg_write,
  input  logic [capi_buffer_pkg::cfg_address_bits-1:0] cfg_address,
  input  logic [capi_buffer_pkg::cfg_data_bits-1:0]    cfg_write_data,
  output logic [capi_buffer_pkg::cfg_data_bits-1:0]    cfg_read_data,
  input  logic                                         tag_parity_error_pulse,
  output logic                                         enabled,
  output logic                                         error_enable,
  output logic                                         odd_parity
);

  logic [capi_buffer_pkg::control_bits-1:0]  control_q;
  logic                                      tag_error_sticky_q;
  logic [capi_buffer_pkg::cfg_data_bits-1:0] error_count_q;

  logic write_control;
  logic clear_status;
  logic clear_count;

  // Address decode
  assign write_control = cfg_write && (cfg_address == capi_buffer_pkg::cfg_control_address);
  assign clear_status  = cfg_write && (cfg_address == capi_buffer_pkg::cfg_status_address);
  assign clear_count   = cfg_write && (cfg_address == capi_buffer_pkg::cfg_count_address);

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      control_q          <= '0;  // Disabled, errors off, even parity
      tag_error_sticky_q <= 1'b0;
      error_count_q      <= '0;
    end else begin
      if (write_control) begin
        control_q <= cfg_write_data[capi_buffer_pkg::control_bits-1:0];
      end
      // Error pulse beats a clear on the same edge
      if (tag_parity_error_pulse) begin
        tag_error_sticky_q <= 1'b1;
      end else if (clear_status) begin
        tag_error_sticky_q <= 1'b0;
      end
      if (tag_parity_error_pulse) begin
        if (error_count_q != capi_buffer_pkg::error_count_max) begin
          error_count_q <= error_count_q + 1'b1;  // Holds at max
        end
      end else if (clear_count) begin
        error_count_q <= '0;
      end
    end
  end

  // Control fields out to the buffer
  assign enabled      = control_q[capi_buffer_pkg::control_enable_bit];
  assign error_enable = control_q[capi_buffer_pkg::control_error_enable_bit];
  assign odd_parity   = control_q[capi_buffer_pkg::control_odd_parity_bit];

  // Readback mux
  always_comb begin
    cfg_read_data = '0;
    case (cfg_address)
      capi_buffer_pkg::cfg_control_address:
        cfg_read_data[capi_buffer_pkg::control_bits-1:0] = control_q;
      capi_buffer_pkg::cfg_status_address:
        cfg_read_data[capi_buffer_pkg::status_tag_parity_bit] = tag_error_sticky_q;
      capi_buffer_pkg::cfg_count_address:
        cfg_read_data = error_count_q;
      default:
        cfg_read_data = '0;  // Unmapped reads as zero
    endcase
  end

endmodule

`default_nettype wire

// File: src/write_data_control.sv
`timescale 1ns/1ps
`default_nettype none

module write_data_control #(
  parameter int DEPTH          = 256,
  parameter int HALF_LINE_BITS = 512
) (
  input  logic                                          clock,
  input  logic                                          rstn,
  input  logic                                          enabled,
  input  logic                                          error_enable,
  input  logic                                          odd_parity,
  input  logic                                          command_write_valid,
  input  logic [capi_buffer_pkg::tag_bits-1:0]          command_tag,
  input  logic [HALF_LINE_BITS-1:0]                     write_data_0,
  input  logic [HALF_LINE_BITS-1:0]                     write_data_1,
  input  logic                                          buffer_read_valid,
  input  logic [capi_buffer_pkg::tag_bits-1:0]          buffer_read_tag,
  input  logic                                          buffer_read_tag_parity,
  input  logic [capi_buffer_pkg::read_address_bits-1:0] buffer_read_address,
  output logic [HALF_LINE_BITS-1:0]                     buffer_read_data,
  output logic [HALF_LINE_BITS/capi_buffer_pkg::double_word_bits-1:0] buffer_read_parity,
  output logic                                          data_write_error,
  output logic                                          tag_parity_error_pulse
);

  localparam int DOUBLE_WORDS = HALF_LINE_BITS / capi_buffer_pkg::double_word_bits;
  localparam int TAG_PAD      = capi_buffer_pkg::double_word_bits - capi_buffer_pkg::tag_bits;

  // Write command stage
  logic                                 write_valid_q;
  logic [capi_buffer_pkg::tag_bits-1:0] write_tag_q;
  logic [HALF_LINE_BITS-1:0]            write_data_0_q;
  logic [HALF_LINE_BITS-1:0]            write_data_1_q;

  // RAM outputs, one per half line
  logic [HALF_LINE_BITS-1:0] ram_data_0;
  logic [HALF_LINE_BITS-1:0] ram_data_1;

  // Read request stage
  logic                                 read_valid_q;   // Request taken while enabled
  logic                                 read_half_q;    // High selects half 1
  logic [capi_buffer_pkg::tag_bits-1:0] read_tag_q;
  logic                                 read_tag_parity_q;  // Parity from the host

  logic expected_tag_parity;
  logic tag_mismatch_q;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      write_valid_q <= 1'b0;
    end else begin
      write_valid_q <= command_write_valid;  // RAM write one edge later
    end
  end

  // Tag travels with its data
  always_ff @(posedge clock) begin
    if (command_write_valid) begin
      write_tag_q    <= command_tag;
      write_data_0_q <= write_data_0;
      write_data_1_q <= write_data_1;
    end
  end

  line_ram #(.WIDTH(HALF_LINE_BITS), .DEPTH(DEPTH)) half_0_ram_i (
    .clock         (clock),
    .write_enable  (write_valid_q),
    .write_address (write_tag_q),
    .write_data    (write_data_0_q),
    .read_address  (buffer_read_tag),   // Raw tag, RAM output lines up with read_valid_q
    .read_data     (ram_data_0)
  );

  line_ram #(.WIDTH(HALF_LINE_BITS), .DEPTH(DEPTH)) half_1_ram_i (
    .clock         (clock),
    .write_enable  (write_valid_q),
    .write_address (write_tag_q),
    .write_data    (write_data_1_q),
    .read_address  (buffer_read_tag),
    .read_data     (ram_data_1)
  );

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      read_valid_q <= 1'b0;
      read_half_q  <= 1'b0;
    end else begin
      read_valid_q <= buffer_read_valid & enabled;  // Dropped when disabled
      read_half_q  <= |buffer_read_address;
    end
  end

  always_ff @(posedge clock) begin
    read_tag_q        <= buffer_read_tag;
    read_tag_parity_q <= buffer_read_tag_parity;
  end

  // Half line select, all ones when idle
  always_comb begin
    if (!read_valid_q) begin
      buffer_read_data = '1;
    end else if (read_half_q) begin
      buffer_read_data = ram_data_1;
    end else begin
      buffer_read_data = ram_data_0;
    end
  end

  dw_parity #(.DOUBLE_WORDS(DOUBLE_WORDS)) data_parity_i (
    .data   (buffer_read_data),
    .odd    (odd_parity),
    .parity (buffer_read_parity)
  );

  ////////////////////////////////////////////////////////////
  // Tag parity check
  ////////////////////////////////////////////////////////////

  // Tag padded out to one double word
  dw_parity #(.DOUBLE_WORDS(1)) tag_parity_i (
    .data   ({{TAG_PAD{1'b0}}, read_tag_q}),
    .odd    (odd_parity),
    .parity (expected_tag_parity)
  );

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_mismatch_q   <= 1'b0;
      data_write_error <= 1'b0;
    end else begin
      tag_mismatch_q   <= read_valid_q & (expected_tag_parity != read_tag_parity_q);
      data_write_error <= tag_mismatch_q & error_enable;  // Reported one edge later
    end
  end

  assign tag_parity_error_pulse = tag_mismatch_q;  // Counted even with reporting off

endmodule

`default_nettype wire

// File: src/dw_parity.sv
`timescale 1ns/1ps
`default_nettype none

// One parity bit per 64-bit double word
// Even sense when odd is low, odd sense when high
module dw_parity #(
  parameter int DOUBLE_WORDS = 8
) (
  input  logic [DOUBLE_WORDS*capi_buffer_pkg::double_word_bits-1:0] data,
  input  logic                                                      odd,
  output logic [DOUBLE_WORDS-1:0]                                   parity
);

  localparam int DW = capi_buffer_pkg::double_word_bits;

  ////////////////////////////////////////////////////////////
  // Per double word reduction
  ////////////////////////////////////////////////////////////

  genvar i;
  generate
    for (i = 0; i < DOUBLE_WORDS; i++) begin : g_dw
      // XOR of the slice gives even parity
      // Inverting it makes the total count odd
      assign parity[i] = (^data[i*DW +: DW]) ^ odd;
    end
  endgenerate

endmodule

`default_nettype wire

// File: src/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual port RAM, one write and one registered read
module line_ram #(
  parameter int WIDTH = 512,
  parameter int DEPTH = 256
) (
  input  logic                     clock,
  input  logic                     write_enable,
  input  logic [$clog2(DEPTH)-1:0] write_address,
  input  logic [WIDTH-1:0]         write_data,
  input  logic [$clog2(DEPTH)-1:0] read_address,
  output logic [WIDTH-1:0]         read_data
);

  logic [WIDTH-1:0] mem [DEPTH];  // One half line per entry

  // Write port
  always_ff @(posedge clock) begin
    if (write_enable) begin
      mem[write_address] <= write_data;
    end
  end

  // Read port, old data returned on a same-edge write
  always_ff @(posedge clock) begin
    read_data <= mem[read_address];
  end

endmodule

`default_nettype wire

// File: src/capi_buffer_pkg.sv
`default_nettype none

package capi_buffer_pkg;

  ////////////////////////////////////////////////////////////
  // Host link widths
  ////////////////////////////////////////////////////////////

  localparam int tag_bits          = 8;   // Command and read tag
  localparam int read_address_bits = 6;   // Zero picks half 0, any other value half 1

  // Cache line geometry
  localparam int half_line_bits         = 512;
  localparam int double_word_bits       = 64;  // Span of one parity bit
  localparam int half_line_double_words = half_line_bits / double_word_bits;

  localparam int buffer_depth = 256;  // One entry per tag value

  ////////////////////////////////////////////////////////////
  // Configuration register map
  ////////////////////////////////////////////////////////////

  localparam int cfg_address_bits = 2;
  localparam int cfg_data_bits    = 8;

  localparam logic [cfg_address_bits-1:0] cfg_control_address = 2'd0;
  localparam logic [cfg_address_bits-1:0] cfg_status_address  = 2'd1;  // Write clears
  localparam logic [cfg_address_bits-1:0] cfg_count_address   = 2'd2;  // Write clears

  // Control register fields
  localparam int control_enable_bit       = 0;
  localparam int control_error_enable_bit = 1;
  localparam int control_odd_parity_bit   = 2;
  localparam int control_bits             = 3;

  // Status register fields
  localparam int status_tag_parity_bit = 0;

  localparam int error_count_max = 255;  // Counter saturates here

endpackage

`default_nettype wire
